//--- sources.f
source/imuldiv_pkg.sv
source/int_div_dpath.sv
source/int_div_ctrl.sv
source/int_div_iterative.sv
source/int_mul_iterative.sv
source/imuldiv_unit.sv
testbench/imuldiv_checker.sv
testbench/imuldiv_tb.sv

//--- testbench/imuldiv_testdata.txt
// columns are fn a b expected in hex
// fn 0 is mul 1 is div 2 is divu and divides expect remainder then quotient
0 00000007 00000006 000000000000002a
0 fffffffd 00000005 fffffffffffffff1
0 fffffff9 fffffffa 000000000000002a
0 00000000 80000000 0000000000000000
0 80000000 80000000 4000000000000000
0 7fffffff 7fffffff 3fffffff00000001
0 80000000 7fffffff c000000080000000
0 ffffffff ffffffff 0000000000000001
0 12345678 00010000 0000123456780000
0 ffffffff 00000001 ffffffffffffffff
1 00000014 00000006 0000000200000003
1 ffffffec 00000006 fffffffefffffffd
1 00000014 fffffffa 00000002fffffffd
1 ffffffec fffffffa fffffffe00000003
1 80000000 ffffffff 0000000080000000
1 00000005 0000000a 0000000500000000
1 7fffffff 80000000 7fffffff00000000
1 fffffff9 00000000 fffffff9ffffffff
2 00000011 00000000 00000011ffffffff
2 ffffffff 00000002 000000017fffffff
2 80000000 00000003 000000022aaaaaaa
2 fffffff0 fffffff1 fffffff000000000
2 00000064 00000007 000000020000000e

//--- testbench/imuldiv_tb.sv
// testbench for imuldiv_unit, vectors come from testbench/imuldiv_testdata.txt
// requests and resp_rdy stalls are driven on the falling edge
`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int MAX_VECS  = 64;
  localparam int STALL_MAX = 3;

  logic         clk;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy;

  // four words per vector: fn, a, b, expected
  logic [63:0] vec_words [0:4*MAX_VECS-1];

  int          num_vecs    = 0;
  int          tb_errors   = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          stall_count = 0;
  logic [31:0] rnd_state   = 32'h860ce80d;

  imuldiv_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  imuldiv_checker scoreboard (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // hold the vector until req_rdy is seen, the transfer is on the next rising edge
  task automatic drive_vector(input int idx);
    req.fn  = muldiv_fn_e'(vec_words[4*idx][1:0]);
    req.a   = vec_words[4*idx+1][31:0];
    req.b   = vec_words[4*idx+2][31:0];
    req_val = 1'b1;
    while (req_rdy !== 1'b1) begin
      @(negedge clk);
    end
    scoreboard.expect_result(vec_words[4*idx+3]);
    @(negedge clk);
  endtask

  task automatic report_counts();
    $display("error count: %0d in responses, %0d in the run (%0d of %0d responses)",
             scoreboard.error_count, tb_errors, scoreboard.resp_count, num_vecs);
  endtask

  // --------------------------------------------------
  // random response back-pressure, at most STALL_MAX low cycles
  // --------------------------------------------------

  always @(negedge clk) begin
    rnd_state = xorshift32(rnd_state);
    if (stall_count >= STALL_MAX || rnd_state[0]) begin
      resp_rdy    = 1'b1;
      stall_count = 0;
    end else begin
      resp_rdy    = 1'b0;
      stall_count = stall_count + 1;
    end
  end

  // --------------------------------------------------
  // timeout
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, responses are missing", cycle_count);
      report_counts();
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk      = 1'b0;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;

    $readmemh("testbench/imuldiv_testdata.txt", vec_words);
    while (num_vecs < MAX_VECS && !$isunknown(vec_words[4*num_vecs])) begin
      num_vecs++;
    end
    if (num_vecs == 0) begin
      $display("no test vectors were read from the data file");
      tb_errors++;
    end
    // transfer, 32 iterations, stalls and the turnaround per vector
    cycle_limit = num_vecs * (36 + STALL_MAX) + 50;

    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < num_vecs; i++) begin
      drive_vector(i);
    end
    req_val = 1'b0;

    while (scoreboard.resp_count < num_vecs) begin
      @(posedge clk);
    end
    // room for any response that should not come
    repeat (40) @(posedge clk);
    if (scoreboard.resp_count > num_vecs) begin
      $display("extra response: %0d responses for %0d requests",
               scoreboard.resp_count, num_vecs);
      tb_errors++;
    end

    report_counts();
    if (tb_errors == 0 && scoreboard.error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/imuldiv_checker.sv
// response checker for the multiply/divide unit
// compares each taken response in order and watches the val/rdy timing
`timescale 1ns/1ps
`default_nettype none

module imuldiv_checker (
  input logic                      clk,
  input logic                      reset,
  input imuldiv_pkg::muldiv_req_t  req,
  input logic                      req_val,
  input logic                      req_rdy,
  input imuldiv_pkg::muldiv_resp_t resp,
  input logic                      resp_val,
  input logic                      resp_rdy
);

  import imuldiv_pkg::*;

  // resp_val goes high after the 32nd iteration edge
  localparam int ITER_EDGES = 32;

  logic [63:0] expected_q[$];
  muldiv_req_t req_q[$];

  int          error_count = 0;
  int          resp_count  = 0;
  int          cycle       = 0;
  int          req_cycle   = 0;
  logic        after_reset = 1'b0;
  logic        outstanding = 1'b0;
  logic        seen_val    = 1'b0;
  logic        held        = 1'b0;
  logic [63:0] held_result = '0;

  // called by the testbench for each request it sends
  task automatic expect_result(input logic [63:0] value);
    expected_q.push_back(value);
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic compare_response();
    logic [63:0] expected;
    muldiv_req_t sent;
    // an unmatched response is left to the testbench count
    if (expected_q.size() > 0 && req_q.size() > 0) begin
      expected = expected_q.pop_front();
      sent     = req_q.pop_front();
      if (resp.result !== expected) begin
        report_error($sformatf("fn %0d a %h b %h gave %h, expected %h",
                               sent.fn, sent.a, sent.b, resp.result, expected));
      end
    end
  endtask

  // --------------------------------------------------
  // sampled on the rising edge, inputs move on the falling one
  // --------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      after_reset = 1'b1;
      outstanding = 1'b0;
      seen_val    = 1'b0;
      held        = 1'b0;
    end else begin
      // first edge out of reset
      if (after_reset) begin
        if (resp_val !== 1'b0 || req_rdy !== 1'b1) begin
          report_error($sformatf("after reset resp_val %b req_rdy %b, expected 0 and 1",
                                 resp_val, req_rdy));
        end
        after_reset = 1'b0;
      end
      // a stalled response must hold
      if (held) begin
        if (resp_val !== 1'b1) begin
          report_error("resp_val dropped before the response was taken");
        end else if (resp.result !== held_result) begin
          report_error($sformatf("stalled result changed from %h to %h",
                                 held_result, resp.result));
        end
      end
      // one operation in flight
      if (outstanding && req_rdy !== 1'b0) begin
        report_error("req_rdy high while an operation is outstanding");
      end
      // latency from the request edge to the first sample of resp_val
      if (resp_val === 1'b1 && outstanding && !seen_val) begin
        seen_val = 1'b1;
        if (cycle - req_cycle != ITER_EDGES + 1) begin
          report_error($sformatf("resp_val seen %0d edges after the request, expected %0d",
                                 cycle - req_cycle, ITER_EDGES + 1));
        end
      end
      if (resp_val === 1'b1 && resp_rdy === 1'b1) begin
        resp_count++;
        compare_response();
        outstanding = 1'b0;
        seen_val    = 1'b0;
        held        = 1'b0;
      end else begin
        held        = (resp_val === 1'b1);
        held_result = resp.result;
      end
      if (req_val === 1'b1 && req_rdy === 1'b1) begin
        outstanding = 1'b1;
        req_cycle   = cycle;
        req_q.push_back(req);
      end
    end
    cycle++;
  end

endmodule

`default_nettype wire

//--- source/imuldiv_unit.sv
// top of the multiply/divide unit, dispatches each request by opcode
// one operation in flight, the owning unit's response goes out
`timescale 1ns/1ps
`default_nettype none

module imuldiv_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  import imuldiv_pkg::*;

  // which unit owns the outstanding operation
  typedef enum logic [1:0] {
    UNIT_NONE,
    UNIT_DIV,
    UNIT_MUL
  } unit_e;

  unit_e busy_unit;

  logic         is_mul;
  logic         div_req_val;
  logic         div_req_rdy;
  muldiv_resp_t div_resp;
  logic         div_resp_val;
  logic         div_resp_rdy;
  logic         mul_req_val;
  logic         mul_req_rdy;
  muldiv_resp_t mul_resp;
  logic         mul_resp_val;
  logic         mul_resp_rdy;

  // --------------------------------------------------
  // request dispatch
  // --------------------------------------------------

  assign is_mul = (req.fn == fn_mul);

  // ready only with nothing outstanding, never looks at req_val
  assign req_rdy = (busy_unit == UNIT_NONE) & div_req_rdy & mul_req_rdy;

  assign div_req_val = req_val & req_rdy & ~is_mul;
  assign mul_req_val = req_val & req_rdy & is_mul;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_unit <= UNIT_NONE;
    end else if (req_val && req_rdy) begin
      busy_unit <= is_mul ? UNIT_MUL : UNIT_DIV;
    end else if (resp_val && resp_rdy) begin
      // response taken, free for the next request
      busy_unit <= UNIT_NONE;
    end
  end

  // --------------------------------------------------
  // units
  // --------------------------------------------------

  int_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  // --------------------------------------------------
  // response mux
  // --------------------------------------------------

  assign div_resp_rdy = resp_rdy & (busy_unit == UNIT_DIV);
  assign mul_resp_rdy = resp_rdy & (busy_unit == UNIT_MUL);

  assign resp_val = ((busy_unit == UNIT_DIV) & div_resp_val)
                  | ((busy_unit == UNIT_MUL) & mul_resp_val);
  assign resp     = (busy_unit == UNIT_MUL) ? mul_resp : div_resp;

endmodule

`default_nettype wire

//--- source/int_mul_iterative.sv
// iterative signed multiplier, one shift-add step per clock
// magnitudes are multiplied and the product sign is applied on output
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  import imuldiv_pkg::*;

  localparam int CW = $clog2(ITER_COUNT);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e        state;
  logic [CW-1:0] count;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (count == CW'(ITER_COUNT - 1)) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // --------------------------------------------------
  // shift-add datapath
  // --------------------------------------------------

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] mcand;  // multiplicand, shifts left
  logic [XLEN-1:0]   mplier; // multiplier, shifts right
  logic [2*XLEN-1:0] acc;
  logic              prod_neg;

  assign a_mag = req.a[XLEN-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[XLEN-1] ? (~req.b + 1'b1) : req.b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand    <= {{XLEN{1'b0}}, a_mag};
      mplier   <= b_mag;
      acc      <= '0;
      prod_neg <= req.a[XLEN-1] ^ req.b[XLEN-1];
    end else if (state == CALC) begin
      // add the aligned multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign resp.result = prod_neg ? (~acc + 1'b1) : acc;

endmodule

`default_nettype wire

//--- source/int_div_iterative.sv
// iterative divider, datapath and control FSM behind val/rdy ports
// result is {remainder, quotient}
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::muldiv_resp_t resp,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  import imuldiv_pkg::*;

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sign_en;

  logic [2*XLEN-1:0] div_result;

  int_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .sign_en   (sign_en),
    .result    (div_result)
  );

  int_div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .resp_rdy  (resp_rdy),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .sign_en   (sign_en)
  );

  // pack into the response payload
  assign resp.result = div_result;

endmodule

`default_nettype wire

//--- source/int_div_ctrl.sv
// divider control FSM, IDLE -> CALC for ITER_COUNT edges -> DONE
// drives the load/iterate enables and selects of int_div_dpath
`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sign_en
);

  import imuldiv_pkg::*;

  localparam int CW = $clog2(ITER_COUNT);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e        state;
  logic [CW-1:0] count;

  logic req_go;
  logic resp_go;

  // handshakes on this edge
  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // --------------------------------------------------
  // state and iteration counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last iteration edge moves straight to DONE
          if (count == CW'(ITER_COUNT - 1)) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          // hold the response until it is taken
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // outputs, decoded from state
  // --------------------------------------------------

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // load only on an accepted request, then iterate through CALC
  assign a_en      = req_go | (state == CALC);
  assign b_en      = req_go;
  assign sign_en   = req_go;
  assign a_mux_sel = (state == CALC);

endmodule

`default_nettype wire

//--- source/int_div_dpath.sv
// divider datapath, restoring shift-subtract on a 65-bit register
// driven by int_div_ctrl; sign handling is done on operand magnitudes
`timescale 1ns/1ps
`default_nettype none

module int_div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::muldiv_req_t  req,
  input  logic                      a_en,
  input  logic                      b_en,
  input  logic                      a_mux_sel,
  input  logic                      sign_en,
  output logic [63:0]               result
);

  import imuldiv_pkg::*;

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  // only the signed divide looks at the sign bits
  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  assign is_signed = (req.fn == fn_div);
  assign a_neg     = is_signed & req.a[XLEN-1];
  assign b_neg     = is_signed & req.b[XLEN-1];
  assign a_mag     = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag     = b_neg ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------
  // shift-subtract step
  // --------------------------------------------------

  // remainder grows in [64:32], quotient shifts in at [31:0]
  logic [2*XLEN:0] a_reg;
  // divisor aligned to the remainder half
  logic [2*XLEN:0] b_reg;

  logic [2*XLEN:0] a_shift;
  logic [2*XLEN:0] a_diff;
  logic [2*XLEN:0] a_step;
  logic [2*XLEN:0] a_mux_out;

  assign a_shift = a_reg << 1;
  assign a_diff  = a_shift - b_reg;

  // negative difference means restore, quotient bit 0
  assign a_step    = a_diff[2*XLEN] ? {a_shift[2*XLEN:1], 1'b0}
                                    : {a_diff[2*XLEN:1], 1'b1};
  assign a_mux_out = a_mux_sel ? a_step : {{(XLEN+1){1'b0}}, a_mag};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {XLEN{1'b0}}};
    end
  end

  // sign and zero flags, captured with the operands
  logic quot_neg;
  logic rem_neg;
  logic div_zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
    end else if (sign_en) begin
      quot_neg <= a_neg ^ b_neg;
      rem_neg  <= a_neg;
      div_zero <= (req.b == '0);
    end
  end

  // --------------------------------------------------
  // sign fix-up
  // --------------------------------------------------

  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;
  logic [XLEN-1:0] quot;
  logic [XLEN-1:0] rem;

  assign quot_mag = a_reg[XLEN-1:0];
  assign rem_mag  = a_reg[2*XLEN-1:XLEN];

  // divide by zero forces all ones, remainder falls out as the dividend
  assign quot = div_zero ? {XLEN{1'b1}}
              : quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  assign result = {rem, quot};

endmodule

`default_nettype wire

//--- source/imuldiv_pkg.sv
// shared types for the iterative multiply/divide unit
// opcode enum, request/response payloads and width constants
`default_nettype none

package imuldiv_pkg;

  // --------------------------------------------------
  // sizing
  // --------------------------------------------------

  // operand width, fixed by the payload structs below
  localparam int XLEN = 32;

  // one result bit per iteration cycle
  localparam int ITER_COUNT = 32;

  // --------------------------------------------------
  // opcodes
  // --------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,  // signed multiply, full 64-bit product
    fn_div  = 2'd1,  // signed divide
    fn_divu = 2'd2   // unsigned divide
  } muldiv_fn_e;

  // --------------------------------------------------
  // payloads
  // --------------------------------------------------

  // request, fn sits in the top two bits
  typedef struct packed {
    muldiv_fn_e      fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } muldiv_req_t;

  // multiply gives the product, divide gives {remainder, quotient}
  typedef struct packed {
    logic [2*XLEN-1:0] result;
  } muldiv_resp_t;

endpackage

`default_nettype wire
